//--- verilog/gfx_video_pkg.sv
package gfx_video_pkg;

	// Memory word and pixel packing.
	localparam int word_bits = 16;
	localparam int pix_bits = 4;
	localparam int pix_per_word = 4;

	// 4 bits per channel, red in the top nibble.
	localparam int color_bits = 12;

	// Word address inside one bank.
	localparam int mem_addr_bits = 14;

	// Line fetch FSM of a bitmap layer.
	typedef enum logic [1:0]
	{
		f_idle,
		f_request,
		f_done
	} fetch_state_t;

endpackage

//--- verilog/gfx_reg_pkg.sv
package gfx_reg_pkg;

	localparam int reg_bits = 12;

	// Decoded host register regions.
	typedef enum logic [2:0]
	{
		sel_palette,
		sel_bgcolor,
		sel_layer0,
		sel_layer1,
		sel_frame,
		sel_none
	} reg_sel_t;

	// Layer register offsets.
	localparam logic [3:0] layer_off_base = 4'd0;
	localparam logic [3:0] layer_off_enable = 4'd1;

	// Base word address, bank bit on top.
	localparam int base_bits = 15;

	localparam int frame_bits = 6;

endpackage

//--- verilog/video_timing.sv
module video_timing
	import gfx_reg_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
)
(
	input  logic CLK,
	input  logic rst_n,
	output logic [9:0] h,
	output logic [9:0] v,
	output logic active,
	output logic hs,
	output logic vs,
	output logic line_start,
	output logic [9:0] next_line,
	output logic [frame_bits-1:0] frame_count
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

	logic h_last;
	logic v_last;

	assign h_last = (h == 10'(H_TOTAL - 1));
	assign v_last = (v == 10'(V_TOTAL - 1));

	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h <= '0;
			v <= '0;
			frame_count <= '0;
		end
		else if (h_last)
		begin
			h <= '0;
			if (v_last)
			begin
				v <= '0;
				frame_count <= frame_count + 1'b1;
			end
			else
				v <= v + 10'd1;
		end
		else
			h <= h + 10'd1;
	end

	assign active = (h < 10'(H_ACTIVE)) && (v < 10'(V_ACTIVE));
	assign hs = !((h >= 10'(H_SYNC_START)) && (h < 10'(H_SYNC_START + H_SYNC)));
	assign vs = !((v >= 10'(V_SYNC_START)) && (v < 10'(V_SYNC_START + V_SYNC)));

	// Fetch window opens with horizontal blanking.
	assign line_start = (h == 10'(H_ACTIVE));
	assign next_line = (v >= 10'(V_ACTIVE - 1)) ? '0 : v + 10'd1;

endmodule

//--- verilog/bitmap_layer.sv
module bitmap_layer
	import gfx_video_pkg::*;
	import gfx_reg_pkg::*;
#(
	parameter int H_ACTIVE = 640
)
(
	input  logic CLK,
	input  logic rst_n,
	input  logic reg_wr,
	input  logic [3:0] reg_offset,
	input  logic [word_bits-1:0] reg_data,
	input  logic line_start,
	input  logic [9:0] next_line,
	input  logic [9:0] h,
	output logic [pix_bits-1:0] pix,
	output logic [base_bits-1:0] req_addr,
	output logic req_valid,
	input  logic [word_bits-1:0] req_data,
	input  logic req_ready
);

	localparam int WORDS = H_ACTIVE / pix_per_word;
	localparam int IDX_BITS = $clog2(WORDS);

	logic [base_bits-1:0] base;
	logic enable;

	fetch_state_t state;
	logic [IDX_BITS-1:0] word_idx;
	logic [mem_addr_bits-1:0] fetch_addr;
	logic [mem_addr_bits-1:0] line_offset;

	logic [word_bits-1:0] line_buf [WORDS];
	logic [IDX_BITS-1:0] rd_word;

	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			base <= '0;
			enable <= 1'b0;
		end
		else if (reg_wr)
		begin
			case (reg_offset)
				layer_off_base: base <= reg_data[base_bits-1:0];
				layer_off_enable: enable <= reg_data[0];
				default: ;
			endcase
		end
	end

	assign line_offset = mem_addr_bits'(next_line * WORDS);

	// One full line is fetched per blanking interval.
	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= f_idle;
			word_idx <= '0;
			fetch_addr <= '0;
		end
		else
		begin
			case (state)
				f_idle:
					if (line_start && enable)
					begin
						state <= f_request;
						word_idx <= '0;
						fetch_addr <= base[mem_addr_bits-1:0] + line_offset;
					end
				f_request:
					if (req_ready)
					begin
						word_idx <= word_idx + 1'b1;
						fetch_addr <= fetch_addr + 1'b1;
						if (word_idx == IDX_BITS'(WORDS - 1))
							state <= f_done;
					end
				f_done:
					state <= f_idle;
				default:
					state <= f_idle;
			endcase
		end
	end

	assign req_valid = (state == f_request);
	assign req_addr = {base[base_bits-1], fetch_addr};

	always_ff @(posedge CLK)
	begin
		if (req_valid && req_ready)
			line_buf[word_idx] <= req_data;
	end

	// Pixel 0 of a word sits in the low nibble.
	assign rd_word = h[IDX_BITS+1:2];

	always_ff @(posedge CLK)
	begin
		if (enable && (h < 10'(H_ACTIVE)))
			pix <= line_buf[rd_word][h[1:0] * pix_bits +: pix_bits];
		else
			pix <= '0;
	end

endmodule

//--- verilog/bank_arbiter.sv
module bank_arbiter
	import gfx_video_pkg::*;
(
	input  logic CLK,
	input  logic rst_n,
	input  logic [mem_addr_bits:0] req0_addr,
	input  logic req0_valid,
	output logic [word_bits-1:0] req0_data,
	output logic req0_ready,
	input  logic [mem_addr_bits:0] req1_addr,
	input  logic req1_valid,
	output logic [word_bits-1:0] req1_data,
	output logic req1_ready,
	output logic [mem_addr_bits-1:0] B1_ADDR,
	output logic B1_VALID,
	input  logic [word_bits-1:0] B1_DIN,
	input  logic B1_READY,
	output logic [mem_addr_bits-1:0] B2_ADDR,
	output logic B2_VALID,
	input  logic [word_bits-1:0] B2_DIN,
	input  logic B2_READY
);

	logic req0_bank;
	logic req1_bank;
	logic [1:0] want0;
	logic [1:0] want1;

	// Owner per bank, 1 means layer 1.
	logic [1:0] owner;
	logic [1:0] owner_q;
	logic [1:0] locked;

	logic [1:0] bank_valid;
	logic [mem_addr_bits-1:0] bank_addr [2];
	logic [1:0] bank_ready;
	logic [word_bits-1:0] bank_din [2];

	assign req0_bank = req0_addr[mem_addr_bits];
	assign req1_bank = req1_addr[mem_addr_bits];

	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		assign want0[b] = req0_valid && (req0_bank == 1'(b));
		assign want1[b] = req1_valid && (req1_bank == 1'(b));

		// A stalled request keeps its bank until the word is taken.
		assign owner[b] = locked[b] ? owner_q[b] : !want0[b];
		assign bank_valid[b] = owner[b] ? want1[b] : want0[b];
		assign bank_addr[b] = owner[b] ? req1_addr[mem_addr_bits-1:0]
			: req0_addr[mem_addr_bits-1:0];

		always_ff @(posedge CLK or negedge rst_n)
		begin
			if (!rst_n)
			begin
				locked[b] <= 1'b0;
				owner_q[b] <= 1'b0;
			end
			else
			begin
				locked[b] <= bank_valid[b] && !bank_ready[b];
				owner_q[b] <= owner[b];
			end
		end
	end

	assign B1_ADDR = bank_addr[0];
	assign B1_VALID = bank_valid[0];
	assign B2_ADDR = bank_addr[1];
	assign B2_VALID = bank_valid[1];
	assign bank_ready = {B2_READY, B1_READY};
	assign bank_din[0] = B1_DIN;
	assign bank_din[1] = B2_DIN;

	assign req0_ready = req0_valid && !owner[req0_bank] && bank_ready[req0_bank];
	assign req1_ready = req1_valid && owner[req1_bank] && bank_ready[req1_bank];
	assign req0_data = bank_din[req0_bank];
	assign req1_data = bank_din[req1_bank];

endmodule

//--- verilog/pixel_mixer.sv
module pixel_mixer
	import gfx_video_pkg::*;
(
	input  logic CLK,
	input  logic rst_n,
	input  logic pal_wr,
	input  logic [pix_bits-1:0] pal_index,
	input  logic bg_wr,
	input  logic [color_bits-1:0] wr_data,
	input  logic [pix_bits-1:0] pix0,
	input  logic [pix_bits-1:0] pix1,
	input  logic active,
	input  logic hs_in,
	input  logic vs_in,
	output logic [3:0] RR,
	output logic [3:0] GG,
	output logic [3:0] BB,
	output logic HS,
	output logic VS
);

	logic [color_bits-1:0] palette [2**pix_bits];
	logic [color_bits-1:0] bg_color;
	logic [pix_bits-1:0] index;
	logic [color_bits-1:0] color;
	logic [color_bits-1:0] rgb_q;
	logic active_d;
	logic hs_d;
	logic vs_d;

	always_ff @(posedge CLK)
	begin
		if (pal_wr)
			palette[pal_index] <= wr_data;
	end

	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
			bg_color <= '0;
		else if (bg_wr)
			bg_color <= wr_data;
	end

	// Layer 0 is on top; index 0 lets the layer below show.
	assign index = (pix0 != '0) ? pix0 : pix1;
	assign color = (index == '0) ? bg_color : palette[index];

	always_ff @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active_d <= 1'b0;
			hs_d <= 1'b1;
			vs_d <= 1'b1;
			rgb_q <= '0;
			HS <= 1'b1;
			VS <= 1'b1;
		end
		else
		begin
			active_d <= active;
			hs_d <= hs_in;
			vs_d <= vs_in;
			rgb_q <= active_d ? color : '0;
			HS <= hs_d;
			VS <= vs_d;
		end
	end

	assign RR = rgb_q[11:8];
	assign GG = rgb_q[7:4];
	assign BB = rgb_q[3:0];

endmodule

//--- verilog/gfx.sv
module gfx
	import gfx_video_pkg::*;
	import gfx_reg_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
)
(
	input  logic CLK,
	input  logic rst_n,
	input  logic [reg_bits-1:0] ADDRESS,
	input  logic [word_bits-1:0] DATA_IN,
	input  logic WR,
	output logic [word_bits-1:0] DATA_OUT,
	output logic HS,
	output logic VS,
	output logic [3:0] RR,
	output logic [3:0] GG,
	output logic [3:0] BB,
	output logic [mem_addr_bits-1:0] B1_ADDR,
	input  logic [word_bits-1:0] B1_DIN,
	output logic B1_VALID,
	input  logic B1_READY,
	output logic [mem_addr_bits-1:0] B2_ADDR,
	input  logic [word_bits-1:0] B2_DIN,
	output logic B2_VALID,
	input  logic B2_READY
);

	reg_sel_t sel;

	logic [9:0] h;
	logic [9:0] next_line;
	logic active;
	logic hs;
	logic vs;
	logic line_start;
	logic [frame_bits-1:0] frame_count;

	logic [pix_bits-1:0] pix0;
	logic [pix_bits-1:0] pix1;
	logic [base_bits-1:0] req0_addr;
	logic [base_bits-1:0] req1_addr;
	logic req0_valid;
	logic req1_valid;
	logic [word_bits-1:0] req0_data;
	logic [word_bits-1:0] req1_data;
	logic req0_ready;
	logic req1_ready;

	always_comb
	begin
		casez (ADDRESS)
			12'hE0?: sel = sel_palette;
			12'hE10: sel = sel_bgcolor;
			12'hD0?: sel = sel_layer0;
			12'hD1?: sel = sel_layer1;
			12'hF00: sel = sel_frame;
			default: sel = sel_none;
		endcase
	end

	// Only the frame counter reads back.
	assign DATA_OUT = (sel == sel_frame) ? word_bits'(frame_count) : '0;

	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_timing (
		.CLK(CLK), .rst_n(rst_n), .h(h), .v(), .active(active), .hs(hs), .vs(vs),
		.line_start(line_start), .next_line(next_line), .frame_count(frame_count)
	);

	bitmap_layer #(.H_ACTIVE(H_ACTIVE)) u_layer0 (
		.CLK(CLK), .rst_n(rst_n), .reg_wr(WR && (sel == sel_layer0)),
		.reg_offset(ADDRESS[3:0]), .reg_data(DATA_IN), .line_start(line_start),
		.next_line(next_line), .h(h), .pix(pix0), .req_addr(req0_addr),
		.req_valid(req0_valid), .req_data(req0_data), .req_ready(req0_ready)
	);

	bitmap_layer #(.H_ACTIVE(H_ACTIVE)) u_layer1 (
		.CLK(CLK), .rst_n(rst_n), .reg_wr(WR && (sel == sel_layer1)),
		.reg_offset(ADDRESS[3:0]), .reg_data(DATA_IN), .line_start(line_start),
		.next_line(next_line), .h(h), .pix(pix1), .req_addr(req1_addr),
		.req_valid(req1_valid), .req_data(req1_data), .req_ready(req1_ready)
	);

	bank_arbiter u_arbiter (
		.CLK(CLK), .rst_n(rst_n),
		.req0_addr(req0_addr), .req0_valid(req0_valid),
		.req0_data(req0_data), .req0_ready(req0_ready),
		.req1_addr(req1_addr), .req1_valid(req1_valid),
		.req1_data(req1_data), .req1_ready(req1_ready),
		.B1_ADDR(B1_ADDR), .B1_VALID(B1_VALID), .B1_DIN(B1_DIN), .B1_READY(B1_READY),
		.B2_ADDR(B2_ADDR), .B2_VALID(B2_VALID), .B2_DIN(B2_DIN), .B2_READY(B2_READY)
	);

	pixel_mixer u_mixer (
		.CLK(CLK), .rst_n(rst_n),
		.pal_wr(WR && (sel == sel_palette)), .pal_index(ADDRESS[3:0]),
		.bg_wr(WR && (sel == sel_bgcolor)), .wr_data(DATA_IN[color_bits-1:0]),
		.pix0(pix0), .pix1(pix1), .active(active), .hs_in(hs), .vs_in(vs),
		.RR(RR), .GG(GG), .BB(BB), .HS(HS), .VS(VS)
	);

endmodule

//--- testbench/tb_clock.sv
module tb_clock
#(
	parameter int PERIOD = 4
)
(
	output logic CLK
);

	initial
	begin
		CLK = 1'b0;
	end

	always
	begin
		#(PERIOD / 2) CLK = ~CLK;
	end

endmodule

//--- testbench/tb_gfx.sv
module tb_gfx
	import gfx_video_pkg::*;
();

	localparam int H_ACTIVE = 32;
	localparam int H_FRONT = 8;
	localparam int H_SYNC = 16;
	localparam int H_BACK = 24;
	localparam int V_ACTIVE = 8;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 2;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int LINE_WORDS = H_ACTIVE / pix_per_word;
	localparam int MEM_WORDS = 2 ** mem_addr_bits;

	// Test 1 takes two frames, tests 2 and 3 three each, test 4 six, test 5 one.
	localparam int NUM_FRAMES = 15;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * H_TOTAL * V_TOTAL + 500;

	logic CLK;
	logic rst_n;
	logic [11:0] address;
	logic [word_bits-1:0] data_in;
	logic wr;
	logic [word_bits-1:0] data_out;
	logic hs;
	logic vs;
	logic [3:0] rr;
	logic [3:0] gg;
	logic [3:0] bb;
	logic [mem_addr_bits-1:0] b1_addr;
	logic [mem_addr_bits-1:0] b2_addr;
	logic [word_bits-1:0] b1_din;
	logic [word_bits-1:0] b2_din;
	logic b1_valid;
	logic b2_valid;
	logic b1_ready;
	logic b2_ready;

	logic [word_bits-1:0] bank1_mem [MEM_WORDS];
	logic [word_bits-1:0] bank2_mem [MEM_WORDS];

	// Register copies for the reference model.
	logic [color_bits-1:0] pal_model [16];
	logic [color_bits-1:0] bg_model;
	logic [14:0] layer_base [2];
	logic layer_en [2];

	int video_cycles;
	int run_cycles = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock #(.PERIOD(4)) u_clock (.CLK(CLK));

	gfx #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_dut (
		.CLK(CLK), .rst_n(rst_n), .ADDRESS(address), .DATA_IN(data_in), .WR(wr),
		.DATA_OUT(data_out), .HS(hs), .VS(vs), .RR(rr), .GG(gg), .BB(bb),
		.B1_ADDR(b1_addr), .B1_DIN(b1_din), .B1_VALID(b1_valid), .B1_READY(b1_ready),
		.B2_ADDR(b2_addr), .B2_DIN(b2_din), .B2_VALID(b2_valid), .B2_READY(b2_ready)
	);

	// Bank data is valid only in a cycle with both VALID and READY high.
	assign b1_din = (b1_valid && b1_ready) ? bank1_mem[b1_addr] : '0;
	assign b2_din = (b2_valid && b2_ready) ? bank2_mem[b2_addr] : '0;

	// Counts the DUT counter position since reset release.
	always @(posedge CLK or negedge rst_n)
	begin
		if (!rst_n)
			video_cycles <= 0;
		else
			video_cycles <= video_cycles + 1;
	end

	always @(posedge CLK)
	begin
		run_cycles <= run_cycles + 1;
	end

	// Stalls never last two cycles in a row.
	always @(negedge CLK)
	begin
		b1_ready <= !b1_ready || (($urandom % 4) != 0);
		b2_ready <= !b2_ready || (($urandom % 4) != 0);
	end

	task automatic note_error();
		test_errors++;
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [15:0] data);
		@(negedge CLK);
		address = addr;
		data_in = data;
		wr = 1'b1;
		@(negedge CLK);
		wr = 1'b0;
		if (addr[11:4] == 8'hE0)
			pal_model[addr[3:0]] = data[color_bits-1:0];
		else if (addr == 12'hE10)
			bg_model = data[color_bits-1:0];
		else if ((addr[11:4] == 8'hD0 || addr[11:4] == 8'hD1) && addr[3:0] == 4'd0)
			layer_base[addr[4]] = data[14:0];
		else if ((addr[11:4] == 8'hD0 || addr[11:4] == 8'hD1) && addr[3:0] == 4'd1)
			layer_en[addr[4]] = data[0];
	endtask

	task automatic read_reg(input logic [11:0] addr, output logic [15:0] value);
		@(negedge CLK);
		address = addr;
		#1;
		value = data_out;
	endtask

	task automatic set_layer(input int l, input logic [14:0] base, input logic en);
		logic [11:0] reg_base;
		reg_base = (l == 0) ? 12'hD00 : 12'hD10;
		write_reg(reg_base, {1'b0, base});
		write_reg(reg_base + 12'd1, {15'd0, en});
	endtask

	task automatic random_colors();
		for (int i = 0; i < 16; i++)
			write_reg(12'hE00 + 12'(i), 16'($urandom));
		write_reg(12'hE10, 16'($urandom));
	endtask

	function automatic logic [3:0] layer_index(input int l, input int h, input int v);
		logic [14:0] base;
		logic [mem_addr_bits-1:0] addr;
		logic [word_bits-1:0] word;
		if (!layer_en[l])
			return 4'd0;
		base = layer_base[l];
		addr = base[13:0] + 14'(v * LINE_WORDS + h / 4);
		word = base[14] ? bank2_mem[addr] : bank1_mem[addr];
		return word[(h % 4) * 4 +: 4];
	endfunction

	// Layer 0 is on top and index 0 is transparent, so the background lies below both.
	function automatic logic [11:0] model_rgb(input int p);
		int h;
		int v;
		logic [3:0] idx;
		h = (p % FRAME) % H_TOTAL;
		v = (p % FRAME) / H_TOTAL;
		if (h >= H_ACTIVE || v >= V_ACTIVE)
			return 12'h000;
		idx = layer_index(0, h, v);
		if (idx == 4'd0)
			idx = layer_index(1, h, v);
		if (idx == 4'd0)
			return bg_model;
		return pal_model[idx];
	endfunction

	task automatic wait_frame_start();
		@(negedge CLK);
		while (video_cycles % FRAME != 0)
			@(negedge CLK);
	endtask

	task automatic check_reset_state();
		assert (!b1_valid && !b2_valid && {rr, gg, bb} == 12'h000 && hs && vs)
		else
		begin
			$display("[ERROR] %0t: reset state VALID %b %b, RGB %h, HS %b, VS %b",
				$time, b1_valid, b2_valid, {rr, gg, bb}, hs, vs);
			note_error();
		end
	endtask

	task automatic check_sync();
		int hs_low [V_TOTAL];
		int hs_first [V_TOTAL];
		int vs_low [V_TOTAL];
		int pos;
		int line;
		int vs_lines;
		for (int i = 0; i < V_TOTAL; i++)
		begin
			hs_low[i] = 0;
			hs_first[i] = -1;
			vs_low[i] = 0;
		end
		wait_frame_start();
		repeat (FRAME)
		begin
			@(negedge CLK);
			pos = (video_cycles - 2) % FRAME;
			line = pos / H_TOTAL;
			if (!hs)
			begin
				if (hs_low[line] == 0)
					hs_first[line] = pos % H_TOTAL;
				hs_low[line]++;
			end
			if (!vs)
				vs_low[line]++;
			assert (!b1_valid && !b2_valid)
			else
			begin
				$display("[ERROR] %0t: bank VALID high with both layers off", $time);
				note_error();
			end
		end
		vs_lines = 0;
		for (int i = 0; i < V_TOTAL; i++)
		begin
			assert (hs_low[i] == H_SYNC && hs_first[i] == H_ACTIVE + H_FRONT)
			else
			begin
				$display("[ERROR] %0t: line %0d has HS low for %0d cycles from x=%0d",
					$time, i, hs_low[i], hs_first[i]);
				note_error();
			end
			if (vs_low[i] == H_TOTAL)
				vs_lines++;
			else
				assert (vs_low[i] == 0)
				else
				begin
					$display("[ERROR] %0t: line %0d has VS low for part of it", $time, i);
					note_error();
				end
		end
		assert (vs_lines == V_SYNC)
		else
		begin
			$display("[ERROR] %0t: VS low for %0d lines", $time, vs_lines);
			note_error();
		end
	endtask

	// The first frame after a register change may still show old line buffers.
	task automatic check_frame();
		int p;
		logic [11:0] exp_rgb;
		wait_frame_start();
		wait_frame_start();
		repeat (FRAME)
		begin
			@(negedge CLK);
			p = video_cycles - 2;
			exp_rgb = model_rgb(p);
			assert ({rr, gg, bb} == exp_rgb)
			else
			begin
				$display("[ERROR] %0t: pixel x=%0d y=%0d is %h, expected %h", $time,
					(p % FRAME) % H_TOTAL, (p % FRAME) / H_TOTAL, {rr, gg, bb}, exp_rgb);
				note_error();
			end
		end
	endtask

	task automatic check_frame_counter();
		logic [11:0] unmapped [3];
		logic [15:0] value;
		int frames;
		unmapped = '{12'h123, 12'hE11, 12'hF01};
		wait_frame_start();
		read_reg(12'hF00, value);
		frames = video_cycles / FRAME;
		assert (value == 16'(frames % 64))
		else
		begin
			$display("[ERROR] %0t: frame count %0d, expected %0d", $time, value, frames % 64);
			note_error();
		end
		for (int i = 0; i < 3; i++)
		begin
			read_reg(unmapped[i], value);
			assert (value == 16'h0000)
			else
			begin
				$display("[ERROR] %0t: address %h reads %h", $time, unmapped[i], value);
				note_error();
			end
		end
	endtask

	task automatic report_test(input int num, input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		total_errors += test_errors;
		$display("Test %0d, %s: %s with %0d errors", num, name,
			(test_errors == 0) ? "pass" : "fail", test_errors);
		test_errors = 0;
	endtask

	initial
	begin : watchdog
		fetch_state_t state0;
		fetch_state_t state1;
		wait (run_cycles >= TIMEOUT_CYCLES);
		state0 = u_dut.u_layer0.state;
		state1 = u_dut.u_layer1.state;
		$display("Timeout: the run did not end within %0d cycles, layer fetch states %s and %s",
			TIMEOUT_CYCLES, state0.name(), state1.name());
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		void'($urandom(69));
		rst_n = 1'b0;
		address = '0;
		data_in = '0;
		wr = 1'b0;
		b1_ready = 1'b1;
		b2_ready = 1'b1;
		bg_model = '0;
		for (int i = 0; i < 16; i++)
			pal_model[i] = '0;
		for (int l = 0; l < 2; l++)
		begin
			layer_base[l] = '0;
			layer_en[l] = 1'b0;
		end
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			bank1_mem[i] = 16'($urandom);
			bank2_mem[i] = 16'($urandom);
		end

		repeat (10) @(negedge CLK);
		check_reset_state();
		rst_n = 1'b1;
		@(negedge CLK);
		check_reset_state();
		check_sync();
		report_test(1, "reset and sync");

		random_colors();
		check_frame();
		report_test(2, "background only");

		set_layer(0, {1'b0, 14'($urandom)}, 1'b1);
		check_frame();
		report_test(3, "single layer");

		set_layer(0, {1'b0, 14'($urandom)}, 1'b1);
		set_layer(1, {1'b0, 14'($urandom)}, 1'b1);
		check_frame();
		set_layer(1, {1'b1, 14'($urandom)}, 1'b1);
		check_frame();
		report_test(4, "priority and arbitration");

		check_frame_counter();
		report_test(5, "frame counter");

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- verilog.f
verilog/gfx_video_pkg.sv
verilog/gfx_reg_pkg.sv
verilog/video_timing.sv
verilog/bitmap_layer.sv
verilog/bank_arbiter.sv
verilog/pixel_mixer.sv
verilog/gfx.sv
testbench/tb_clock.sv
testbench/tb_gfx.sv

//--- Makefile
TOP = tb_gfx

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard verilog/*.sv testbench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module gfx -f verilog.f

clean:
	rm -rf obj_dir sim.log
